// ==== Bender.yml ====
package:
  name: countdown_display

sources:
  - src/countdown_pkg.sv
  - src/tick_generator.sv
  - src/countdown_ctrl.sv
  - src/dot_matrix_scan.sv
  - src/countdown_display_top.sv
  - target: test
    files:
      - test/countdown_display_assertions.sv
      - test/countdown_display_tb.sv

// ==== sim.f ====
src/countdown_pkg.sv
src/tick_generator.sv
src/countdown_ctrl.sv
src/dot_matrix_scan.sv
src/countdown_display_top.sv
test/countdown_display_assertions.sv
test/countdown_display_tb.sv

// ==== src/countdown_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module countdown_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start_req,
    input  logic [countdown_pkg::COUNT_W-1:0] start_value,
    input  logic                            second_tick,
    output logic                            start_ack,
    output logic [countdown_pkg::COUNT_W-1:0] count,
    output logic                            done
);
    import countdown_pkg::*;

    logic load;
    logic dec;

    // A new request is taken only while the previous one is fully closed.
    assign load = start_req && !start_ack;
    assign dec  = second_tick && (count != '0);

    // Four-phase handshake.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            start_ack <= 1'b0;
        else if (load)
            start_ack <= 1'b1;
        else if (!start_req)
            start_ack <= 1'b0;              // Host has let go.
    end

    // Load wins over a decrement in the same cycle.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            count <= '0;
        else if (load)
            count <= start_value;
        else if (dec)
            count <= count - COUNT_W'(1);
    end

    // Done marks a countdown that ran out, not a load of zero.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            done <= 1'b0;
        else if (load)
            done <= 1'b0;
        else if (dec && (count == COUNT_W'(1)))
            done <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== src/countdown_display_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module countdown_display_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start_req,
    input  logic [countdown_pkg::COUNT_W-1:0] start_value,
    input  logic                              display_en,
    output logic                              start_ack,
    output logic [countdown_pkg::COUNT_W-1:0] count,
    output logic                              done,
    output logic [countdown_pkg::ROWS-1:0]    row,
    output logic [countdown_pkg::ROWS-1:0]    colr,
    output logic [countdown_pkg::ROWS-1:0]    colg
);

    logic scan_tick;
    logic second_tick;

    tick_generator u_tick (
        .clk         (clk),
        .rst         (rst),
        .scan_tick   (scan_tick),
        .second_tick (second_tick)
    );

    countdown_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start_req   (start_req),
        .start_value (start_value),
        .second_tick (second_tick),
        .start_ack   (start_ack),
        .count       (count),
        .done        (done)
    );

    // Scanner shows the same count that leaves on the top port.
    dot_matrix_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .display_en (display_en),
        .scan_tick  (scan_tick),
        .count      (count),
        .row        (row),
        .colr       (colr),
        .colg       (colg)
    );

endmodule

`default_nettype wire

// ==== src/countdown_pkg.sv ====
`default_nettype none

package countdown_pkg;

    // Panel geometry, square matrix.
    localparam int ROWS    = 8;
    localparam int ROW_W   = 3;

    // Count and start value.
    localparam int COUNT_W   = 3;
    localparam int COUNT_MAX = 7;              // Shown as the heart.

    // Prescaler, kept tiny so a run stays short in simulation.
    localparam int SCAN_DIV         = 4;       // Clocks per scan tick.
    localparam int SCANS_PER_SECOND = 16;      // Two full frames.

    // Counter widths that follow from the prescaler values.
    localparam int SCAN_DIV_W = $clog2(SCAN_DIV);
    localparam int SECOND_W   = $clog2(SCANS_PER_SECOND);

endpackage

`default_nettype wire

// ==== src/dot_matrix_scan.sv ====
`timescale 1ns/10ps
`default_nettype none

module dot_matrix_scan (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              display_en,
    input  logic                              scan_tick,
    input  logic [countdown_pkg::COUNT_W-1:0] count,
    output logic [countdown_pkg::ROWS-1:0]    row,
    output logic [countdown_pkg::ROWS-1:0]    colr,
    output logic [countdown_pkg::ROWS-1:0]    colg
);
    import countdown_pkg::*;

    // Row 0 is the leftmost byte; column bit 7 is the left edge.
    typedef logic [0:ROWS-1][ROWS-1:0] glyph_t;

    logic [ROW_W-1:0] row_idx;
    logic [ROW_W-1:0] next_idx;
    glyph_t           glyph;
    logic [ROWS-1:0]  shape_row;
    logic             red_on;
    logic             green_on;

    function automatic glyph_t glyph_of(input logic [COUNT_W-1:0] value);
        glyph_t g;
        case (value)
            3'd7:    g = {8'h00, 8'h66, 8'hFF, 8'hFF, 8'hFF, 8'h7E, 8'h3C, 8'h18};
            3'd6:    g = {8'h00, 8'h3C, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h66, 8'h3C};
            3'd5:    g = {8'h00, 8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C};
            3'd4:    g = {8'h00, 8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C};
            3'd3:    g = {8'h00, 8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C};
            3'd2:    g = {8'h00, 8'h3C, 8'h66, 8'h06, 8'h0C, 8'h30, 8'h60, 8'h7E};
            3'd1:    g = {8'h00, 8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E};
            default: g = {8'h00, 8'h3C, 8'h66, 8'h66, 8'h66, 8'h66, 8'h66, 8'h3C};
        endcase
        return g;
    endfunction

    assign glyph     = glyph_of(count);
    assign next_idx  = row_idx + ROW_W'(1);
    assign shape_row = glyph[next_idx];

    // Yellow is both colours lit: heart, 3 and 2.
    assign red_on   = (count >= COUNT_W'(2));
    assign green_on = (count == COUNT_W'(COUNT_MAX)) || (count <= COUNT_W'(3));

    // Row and columns come out of the same register stage.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= ROW_W'(ROWS - 1);    // Next tick shows row 0.
            row     <= '1;
            colr    <= '0;
            colg    <= '0;
        end
        else if (!display_en)
        begin
            row_idx <= ROW_W'(ROWS - 1);
            row     <= '1;
            colr    <= '0;
            colg    <= '0;
        end
        else if (scan_tick)
        begin
            row_idx <= next_idx;
            row     <= ~(ROWS'(1) << next_idx);  // Active low, one row at a time.
            colr    <= red_on ? shape_row : '0;
            colg    <= green_on ? shape_row : '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/tick_generator.sv ====
`timescale 1ns/10ps
`default_nettype none

module tick_generator (
    input  logic clk,
    input  logic rst,
    output logic scan_tick,
    output logic second_tick
);
    import countdown_pkg::*;

    logic [SCAN_DIV_W-1:0] div_cnt;
    logic [SECOND_W-1:0]   scan_cnt;

    assign scan_tick   = (div_cnt == SCAN_DIV_W'(SCAN_DIV - 1));
    assign second_tick = scan_tick && (scan_cnt == SECOND_W'(SCANS_PER_SECOND - 1));

    // First stage, clock cycles per scan tick.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            div_cnt <= '0;
        else if (scan_tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + SCAN_DIV_W'(1);
    end

    // Second stage advances only on scan ticks.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            scan_cnt <= '0;
        else if (second_tick)
            scan_cnt <= '0;
        else if (scan_tick)
            scan_cnt <= scan_cnt + SECOND_W'(1);
    end

endmodule

`default_nettype wire

// ==== test/countdown_display_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module countdown_display_assertions (
    input logic                              clk,
    input logic                              rst,
    input logic                              start_req,
    input logic                              start_ack,
    input logic [countdown_pkg::COUNT_W-1:0] count,
    input logic                              display_en,
    input logic [countdown_pkg::ROWS-1:0]    row,
    input logic [countdown_pkg::ROWS-1:0]    colr,
    input logic [countdown_pkg::ROWS-1:0]    colg
);

    int fail_count;                         // Failed assertions so far.

    initial
    begin
        fail_count = 0;
    end

    // The host may already have dropped the request when the rise is seen.
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(start_ack) |-> $past(start_req))
        else
        begin
            $error("start_ack rose without a pending start_req");
            fail_count++;
        end

    row_shape: assert property (@(posedge clk) disable iff (rst)
        $onehot(~row) || (row == '1))
        else
        begin
            $error("row is neither one-cold nor all ones");
            fail_count++;
        end

    blank_idle: assert property (@(posedge clk) disable iff (rst)
        !display_en |=> (row == '1) && (colr == '0) && (colg == '0))
        else
        begin
            $error("panel not blanked after display_en went low");
            fail_count++;
        end

    count_up_on_load: assert property (@(posedge clk) disable iff (rst)
        (count > $past(count)) |-> $rose(start_ack))
        else
        begin
            $error("count rose without a start acknowledge");
            fail_count++;
        end

endmodule

bind countdown_display_top countdown_display_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .start_req  (start_req),
    .start_ack  (start_ack),
    .count      (count),
    .display_en (display_en),
    .row        (row),
    .colr       (colr),
    .colg       (colg)
);

`default_nettype wire

// ==== test/countdown_display_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module countdown_display_tb;
    import countdown_pkg::*;

    localparam int    CLK_HALF      = 2;
    localparam int    RESET_CYCLES  = 5;
    localparam int    RAND_SEED     = 35986;
    localparam int    NUM_CMDS      = 6;
    localparam int    CMD_BASE      = 16 * (COUNT_MAX + 1);   // Glyph bytes come first.
    localparam int    GOLDEN_LEN    = CMD_BASE + 2 * NUM_CMDS;
    localparam int    SECOND_CYCLES = SCAN_DIV * SCANS_PER_SECOND;
    localparam int    ACK_TIMEOUT   = 16;
    localparam string GOLDEN_FILE   = "test/countdown_golden.txt";

    logic               clk;
    logic               rst;
    logic               start_req;
    logic [COUNT_W-1:0] start_value;
    logic               display_en;
    logic               start_ack;
    logic [COUNT_W-1:0] count;
    logic               done;
    logic [ROWS-1:0]    row;
    logic [ROWS-1:0]    colr;
    logic [ROWS-1:0]    colg;

    logic [7:0]         golden [0:GOLDEN_LEN-1];
    bit                 mon_on;
    logic [ROWS-1:0]    prev_row;
    logic [COUNT_W-1:0] prev_count;
    logic               prev_ack;
    int                 last_idx;
    bit                 expect_row0;

    countdown_display_top UUT (
        .clk         (clk),
        .rst         (rst),
        .start_req   (start_req),
        .start_value (start_value),
        .display_en  (display_en),
        .start_ack   (start_ack),
        .count       (count),
        .done        (done),
        .row         (row),
        .colr        (colr),
        .colg        (colg)
    );

    always #CLK_HALF clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
            abort_run($sformatf("** Error at %0d ns: %s expected 0x%0h, actual 0x%0h",
                                $time, name, expected, actual));
    endtask

    task automatic step();
        @(posedge clk);
        #1;                                     // Drive and sample clear of the edge.
    endtask

    task automatic check_idle_outputs();
        check_value("row", 8'hFF, row);
        check_value("colr", 8'h00, colr);
        check_value("colg", 8'h00, colg);
        check_value("start_ack", 0, start_ack);
        check_value("done", 0, done);
        check_value("count", 0, count);
    endtask

    task automatic check_bound_assertions();
        assert (UUT.u_assertions.fail_count == 0)
        else
            abort_run("A bound assertion on the handshake, row or count rules failed.");
    endtask

    task automatic do_handshake(input logic [COUNT_W-1:0] value);
        int n;
        int hold;
        start_value = value;
        start_req   = 1'b1;
        n = 0;
        while (start_ack !== 1'b1 && n < ACK_TIMEOUT)
        begin
            step();
            n++;
        end
        assert (start_ack === 1'b1)
        else
            abort_run("Timeout: start_ack did not rise after start_req was raised.");
        check_value("start_ack latency", 1, n);
        check_value("count", value, count);
        check_value("done", 0, done);
        hold = $urandom_range(0, 3);
        repeat (hold) step();
        start_req = 1'b0;
        n = 0;
        while (start_ack !== 1'b0 && n < ACK_TIMEOUT)
        begin
            step();
            n++;
        end
        assert (start_ack === 1'b0)
        else
            abort_run("Timeout: start_ack did not fall after start_req was dropped.");
    endtask

    task automatic blank_display();
        int delay;
        int len;
        delay = $urandom_range(2, 12);
        len   = $urandom_range(8, 24);
        repeat (delay) step();
        display_en = 1'b0;
        repeat (len)
        begin
            step();
            check_value("row", 8'hFF, row);
            check_value("colr", 8'h00, colr);
            check_value("colg", 8'h00, colg);
        end
        display_en = 1'b1;
    endtask

    task automatic wait_done(input logic [COUNT_W-1:0] value);
        int n;
        int limit;
        limit = (int'(value) + 1) * SECOND_CYCLES + 32;
        n = 0;
        while (count !== '0 && n < limit)
        begin
            step();
            n++;
        end
        assert (count === '0)
        else
            abort_run("Timeout: count did not reach zero.");
        check_value("done", (value != 0), done);   // A load of zero never sets done.
        repeat (SECOND_CYCLES + 8)
        begin
            step();
            check_value("count", 0, count);
            check_value("done", (value != 0), done);
        end
    endtask

    task automatic wait_first_decrement(input logic [COUNT_W-1:0] value);
        int n;
        n = 0;
        while (count === value && n < SECOND_CYCLES + 16)
        begin
            step();
            n++;
        end
        assert (count !== value)
        else
            abort_run("Timeout: count did not decrement after the load.");
    endtask

    task automatic run_command(input logic [COUNT_W-1:0] value, input logic [1:0] flags);
        int gap;
        gap = $urandom_range(0, 5);
        repeat (gap) step();
        do_handshake(value);
        if (flags[0])
            blank_display();
        if (flags[1])
            wait_first_decrement(value);        // Next command restarts mid-count.
        else
            wait_done(value);
    endtask

    task automatic check_count_step();
        logic [COUNT_W-1:0] expected_count;
        expected_count = prev_count - 1'b1;
        if (count !== prev_count && !(start_ack === 1'b1 && prev_ack === 1'b0))
            check_value("count", expected_count, count);
        if (count !== '0)
            check_value("done", 0, done);
    endtask

    task automatic check_scan_step();
        int idx;
        int zeros;
        idx   = 0;
        zeros = 0;
        if (row !== prev_row && row !== '1)
        begin
            for (int b = 0; b < ROWS; b++)
            begin
                if (row[b] === 1'b0)
                begin
                    idx = b;
                    zeros++;
                end
            end
            assert (zeros == 1)
            else
                abort_run($sformatf("Row drive 0x%0h is neither one-cold nor idle.", row));
            if (expect_row0)
                check_value("row index", 0, idx);
            else
                check_value("row index", (last_idx + 1) % ROWS, idx);
            // Columns were registered from the count before this edge.
            check_value("colr", golden[prev_count * 16 + idx], colr);
            check_value("colg", golden[prev_count * 16 + 8 + idx], colg);
            last_idx    = idx;
            expect_row0 = 1'b0;
        end
        if (display_en === 1'b0)
            expect_row0 = 1'b1;
    endtask

    always @(negedge clk)
    begin
        if (mon_on)
        begin
            check_bound_assertions();
            check_count_step();
            check_scan_step();
        end
        prev_row   = row;
        prev_count = count;
        prev_ack   = start_ack;
    end

    initial
    begin
        clk         = 1'b0;
        rst         = 1'b1;
        start_req   = 1'b0;
        start_value = '0;
        display_en  = 1'b1;
        mon_on      = 1'b0;
        expect_row0 = 1'b1;
        last_idx    = 0;
        void'($urandom(RAND_SEED));
        for (int i = 0; i < GOLDEN_LEN; i++)
            golden[i] = 'x;
        $readmemh(GOLDEN_FILE, golden);
        assert (!$isunknown(golden[GOLDEN_LEN-1]))
        else
            abort_run("The golden file could not be read completely.");

        repeat (RESET_CYCLES)
        begin
            step();
            check_idle_outputs();
        end
        rst = 1'b0;
        step();
        check_idle_outputs();
        mon_on = 1'b1;

        for (int i = 0; i < NUM_CMDS; i++)
            run_command(golden[CMD_BASE + 2 * i][COUNT_W-1:0],
                        golden[CMD_BASE + 2 * i + 1][1:0]);

        step();
        if (UUT.u_assertions.fail_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/countdown_golden.txt ====
// Glyphs, one line per count 0 to 7: red bytes for rows 0..7, then green bytes for rows 0..7.
00 00 00 00 00 00 00 00 00 3C 66 66 66 66 66 3C
00 00 00 00 00 00 00 00 00 18 38 18 18 18 18 7E
00 3C 66 06 0C 30 60 7E 00 3C 66 06 0C 30 60 7E
00 3C 66 06 1C 06 66 3C 00 3C 66 06 1C 06 66 3C
00 0C 1C 2C 4C 7E 0C 0C 00 00 00 00 00 00 00 00
00 7E 60 7C 06 06 66 3C 00 00 00 00 00 00 00 00
00 3C 60 7C 66 66 66 3C 00 00 00 00 00 00 00 00
00 66 FF FF FF 7E 3C 18 00 66 FF FF FF 7E 3C 18
// Commands: start value, flags (bit 0 blanks the display, bit 1 restarts before done).
07 00
05 02
03 01
06 01
02 02
01 00
